// ==== llc_defines.svh ====
// llc slice local storage
// geometry and field widths shared by packages and RTL
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// cache geometry
`define LLC_WAYS 4
`define LLC_WAY_BITS 2

// 64 sets
`define LLC_SET_BITS 6

// attribute fields
`define LLC_TAG_BITS 12
`define LLC_OWNER_BITS 3
`define LLC_HPROT_BITS 1

// coherence fields, dirty bit is a single flag
`define LLC_STATE_BITS 3
`define LLC_SHARERS_BITS 8

// one data line per way
`define LLC_LINE_BITS 64

`endif

// ==== llc_mem_pkg.sv ====
// llc slice local storage
// field types and per-payload entry structs kept in the way arrays
`include "llc_defines.svh"

package llc_mem_pkg;

    // addressing
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    // stored fields
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_STATE_BITS-1:0] llc_state_t;
    typedef logic [`LLC_SHARERS_BITS-1:0] sharers_t;
    typedef logic [`LLC_OWNER_BITS-1:0] owner_t;
    typedef logic [`LLC_HPROT_BITS-1:0] hprot_t;
    typedef logic [`LLC_LINE_BITS-1:0] line_t;

    // fields a reset/flush write may touch, 12 bits
    typedef struct packed {
        llc_state_t state;
        sharers_t sharers;
        logic dirty;
    } llc_coh_t;

    // fields written only by a normal write, 16 bits
    typedef struct packed {
        llc_tag_t tag;
        owner_t owner;
        hprot_t hprot;
    } llc_attr_t;

endpackage

// ==== llc_port_pkg.sv ====
// llc slice local storage
// write request and per-way read record seen at the top-level boundary
`include "llc_defines.svh"

package llc_port_pkg;

    import llc_mem_pkg::*;

    // one write request per cycle
    typedef struct packed {
        llc_set_t set;
        llc_way_t way;
        logic wr_en;
        logic wr_en_evict_way;
        // one bit per way, coherence fields only
        logic [`LLC_WAYS-1:0] rst_flush;
        llc_coh_t coh_data;
        llc_attr_t attr_data;
        line_t line_data;
        llc_way_t evict_way;
    } llc_wr_req_t;

    // everything read back for one way, 92 bits
    typedef struct packed {
        llc_coh_t coh;
        llc_attr_t attr;
        line_t line_data;
    } llc_rd_way_t;

endpackage

// ==== llc_write_decode.sv ====
// llc write decoder
// per-way write enables for the coherence and data arrays
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_write_decode (
    input llc_port_pkg::llc_wr_req_t wr_req,
    output logic [`LLC_WAYS-1:0] coh_we,
    output logic [`LLC_WAYS-1:0] data_we
    );

    import llc_mem_pkg::*;

    // a normal write lands in the addressed way only
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            data_we[w] = wr_req.wr_en && (wr_req.way == llc_way_t'(w));
        end
    end

    // flush mask opens the coherence store of every masked way
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            coh_we[w] = wr_req.rst_flush[w] || data_we[w];
        end
    end

    a_way_known: assert final (!wr_req.wr_en || !$isunknown(wr_req.way))
        else $error("write enable with unknown way");

endmodule

// ==== llc_way_array.sv ====
// llc way array
// set-addressed store with per-way write enables and a registered all-ways read
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_way_array #(
    parameter type payload_t = logic [7:0]
    ) (
    input logic clk,
    input logic arst_n,
    input logic [`LLC_SET_BITS-1:0] set,
    input logic [`LLC_WAYS-1:0] we,
    input payload_t wdata,
    input logic rd_en,
    output payload_t [`LLC_WAYS-1:0] rdata
    );

    localparam int NUM_SETS = 1 << `LLC_SET_BITS;

    // one memory per way
    payload_t mem [`LLC_WAYS][NUM_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (we[w]) begin
                mem[w][set] <= wdata;
            end
        end
    end

    // read-first, a same-edge write shows up on the next strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                rdata[w] <= mem[w][set];
            end
        end
    end

    a_set_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|we) |-> !$isunknown(set)
    ) else $error("write to unknown set");

endmodule

// ==== llc_set_view.sv ====
// llc set view
// eviction pointer store and per-way read records built from the three arrays
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_set_view (
    input logic clk,
    input logic arst_n,
    input llc_mem_pkg::llc_set_t set,
    input logic rd_en,
    input logic wr_en_evict_way,
    input llc_mem_pkg::llc_way_t wr_evict_way,
    input llc_mem_pkg::llc_coh_t [`LLC_WAYS-1:0] coh_rd,
    input llc_mem_pkg::llc_attr_t [`LLC_WAYS-1:0] attr_rd,
    input llc_mem_pkg::line_t [`LLC_WAYS-1:0] line_rd,
    output llc_port_pkg::llc_rd_way_t [`LLC_WAYS-1:0] rd_ways,
    output llc_mem_pkg::llc_way_t rd_evict_way
    );

    import llc_mem_pkg::*;
    import llc_port_pkg::*;

    localparam int NUM_SETS = 1 << `LLC_SET_BITS;

    // one pointer per set
    llc_way_t evict_mem [NUM_SETS];
    llc_way_t evict_q;

    always_ff @(posedge clk) begin
        if (wr_en_evict_way) begin
            evict_mem[set] <= wr_evict_way;
        end
    end

    // same strobe and latency as the way arrays
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            evict_q <= '0;
        end else if (rd_en) begin
            evict_q <= evict_mem[set];
        end
    end

    assign rd_evict_way = evict_q;

    // regroup the registered array reads
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            rd_ways[w] = llc_rd_way_t'{coh_rd[w], attr_rd[w], line_rd[w]};
        end
    end

    a_evict_way_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en_evict_way |-> !$isunknown(wr_evict_way) &&
            (int'(wr_evict_way) < `LLC_WAYS)
    ) else $error("eviction way out of range");

endmodule

// ==== llc_localmem.sv ====
// llc local memory top
// write decoder, three payload way arrays and the set view
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_localmem (
    input logic clk,
    input logic arst_n,
    input logic rd_en,
    input llc_port_pkg::llc_wr_req_t wr_req,
    output llc_port_pkg::llc_rd_way_t [`LLC_WAYS-1:0] rd_ways,
    output llc_mem_pkg::llc_way_t rd_evict_way
    );

    import llc_mem_pkg::*;

    logic [`LLC_WAYS-1:0] coh_we;
    logic [`LLC_WAYS-1:0] data_we;

    llc_coh_t [`LLC_WAYS-1:0] coh_rd;
    llc_attr_t [`LLC_WAYS-1:0] attr_rd;
    line_t [`LLC_WAYS-1:0] line_rd;

    llc_write_decode decode_i (
        .wr_req(wr_req),
        .coh_we(coh_we),
        .data_we(data_we)
    );

    // flush reaches this one only
    llc_way_array #(.payload_t(llc_coh_t)) coh_array_i (
        .clk(clk),
        .arst_n(arst_n),
        .set(wr_req.set),
        .we(coh_we),
        .wdata(wr_req.coh_data),
        .rd_en(rd_en),
        .rdata(coh_rd)
    );

    llc_way_array #(.payload_t(llc_attr_t)) attr_array_i (
        .clk(clk),
        .arst_n(arst_n),
        .set(wr_req.set),
        .we(data_we),
        .wdata(wr_req.attr_data),
        .rd_en(rd_en),
        .rdata(attr_rd)
    );

    llc_way_array #(.payload_t(line_t)) line_array_i (
        .clk(clk),
        .arst_n(arst_n),
        .set(wr_req.set),
        .we(data_we),
        .wdata(wr_req.line_data),
        .rd_en(rd_en),
        .rdata(line_rd)
    );

    llc_set_view set_view_i (
        .clk(clk),
        .arst_n(arst_n),
        .set(wr_req.set),
        .rd_en(rd_en),
        .wr_en_evict_way(wr_req.wr_en_evict_way),
        .wr_evict_way(wr_req.evict_way),
        .coh_rd(coh_rd),
        .attr_rd(attr_rd),
        .line_rd(line_rd),
        .rd_ways(rd_ways),
        .rd_evict_way(rd_evict_way)
    );

endmodule

// ==== tb_llc_localmem.sv ====
// testbench for the llc local memory
// random writes, flushes and eviction updates checked against a reference model
`timescale 1ns/1ps
`include "llc_defines.svh"

module tb_llc_localmem;

    import llc_mem_pkg::*;
    import llc_port_pkg::*;

    localparam int NUM_SETS = 1 << `LLC_SET_BITS;
    localparam int WAIT_LIMIT = 20;

    logic clk;
    logic arst_n;
    logic rd_en;
    llc_wr_req_t wr_req;
    llc_rd_way_t [`LLC_WAYS-1:0] rd_ways;
    llc_way_t rd_evict_way;

    // reference model keyed by set*ways+way or by set
    llc_coh_t m_coh [int];
    llc_attr_t m_attr [int];
    line_t m_line [int];
    llc_way_t m_evict [int];

    // expected read data taken when the strobe goes out
    llc_rd_way_t exp_rd [`LLC_WAYS];
    bit exp_valid [`LLC_WAYS];
    llc_way_t exp_evict;
    bit exp_evict_valid;

    int cycle_cnt;
    int rd_cycle;
    int checks;
    int errors;
    int test_checks;
    int test_errors;
    int tests_run;
    bit timed_out;

    llc_localmem dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .rd_en(rd_en),
        .wr_req(wr_req),
        .rd_ways(rd_ways),
        .rd_evict_way(rd_evict_way)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int entry_key(llc_set_t s, int w);
        return int'(s) * `LLC_WAYS + w;
    endfunction

    function automatic llc_wr_req_t rand_write_req(llc_set_t s, llc_way_t w);
        llc_wr_req_t req;
        logic [31:0] r;
        req = '0;
        req.set = s;
        req.way = w;
        req.wr_en = 1'b1;
        r = $urandom;
        req.coh_data = r[$bits(llc_coh_t)-1:0];
        r = $urandom;
        req.attr_data = r[$bits(llc_attr_t)-1:0];
        req.line_data = {$urandom, $urandom};
        return req;
    endfunction

    // expected contents of one set before this edge's writes land
    function automatic void snapshot_set(llc_set_t s);
        int k;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            k = entry_key(s, w);
            exp_valid[w] = m_attr.exists(k);
            if (exp_valid[w]) begin
                exp_rd[w] = '{coh: m_coh[k], attr: m_attr[k], line_data: m_line[k]};
            end
        end
        exp_evict_valid = m_evict.exists(int'(s));
        if (exp_evict_valid) begin
            exp_evict = m_evict[int'(s)];
        end
    endfunction

    // flush touches coherence only and a normal write the whole entry
    function automatic void model_apply(llc_wr_req_t req);
        int k;
        bit hit;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            k = entry_key(req.set, w);
            hit = req.wr_en && (req.way == llc_way_t'(w));
            if (req.rst_flush[w] || hit) begin
                m_coh[k] = req.coh_data;
            end
            if (hit) begin
                m_attr[k] = req.attr_data;
                m_line[k] = req.line_data;
            end
        end
        if (req.wr_en_evict_way) begin
            m_evict[int'(req.set)] = req.evict_way;
        end
    endfunction

    task automatic drive_cycle(llc_wr_req_t req, bit rd);
        wr_req = req;
        rd_en = rd;
        if (rd) begin
            snapshot_set(req.set);
            rd_cycle = cycle_cnt;
        end
        next_cycle();
        model_apply(req);
        wr_req = '0;
        rd_en = 1'b0;
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic wait_read();
        int guard;
        guard = 0;
        while (cycle_cnt <= rd_cycle && guard < WAIT_LIMIT) begin
            guard++;
            next_cycle();
        end
        if (cycle_cnt <= rd_cycle) begin
            $display("read data did not arrive within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
            finish_run();
        end
    endtask

    task automatic read_set(llc_set_t s);
        llc_wr_req_t req;
        req = '0;
        req.set = s;
        drive_cycle(req, 1'b1);
        wait_read();
    endtask

    task automatic check_way(string name, llc_rd_way_t exp, llc_rd_way_t act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_evict(string name, llc_way_t exp, llc_way_t act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_set(string name);
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (exp_valid[w]) begin
                check_way(name, exp_rd[w], rd_ways[w]);
            end
        end
        if (exp_evict_valid) begin
            check_evict(name, exp_evict, rd_evict_way);
        end
    endtask

    task automatic end_test(string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        llc_wr_req_t req;
        llc_set_t s;
        llc_way_t w;

        void'($urandom(32'h8e45_48c2));
        clk = 1'b0;
        arst_n = 1'b0;
        rd_en = 1'b0;
        wr_req = '0;
        cycle_cnt = 0;
        rd_cycle = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // read registers come out of reset cleared
        for (int i = 0; i < `LLC_WAYS; i++) begin
            check_way("after_reset", '0, rd_ways[i]);
        end
        check_evict("after_reset", '0, rd_evict_way);
        end_test("after_reset");

        for (int i = 0; i < 40; i++) begin
            s = llc_set_t'($urandom_range(NUM_SETS - 1));
            w = llc_way_t'($urandom_range(`LLC_WAYS - 1));
            drive_cycle(rand_write_req(s, w), 1'b0);
            read_set(s);
            compare_set("random_rw");
        end
        end_test("random_rw");

        // fill one set completely, then flush random masks over it
        s = llc_set_t'($urandom_range(NUM_SETS - 1));
        for (int i = 0; i < `LLC_WAYS; i++) begin
            drive_cycle(rand_write_req(s, llc_way_t'(i)), 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            req = rand_write_req(s, '0);
            req.wr_en = 1'b0;
            req.rst_flush = 4'($urandom_range(15));
            drive_cycle(req, 1'b0);
            read_set(s);
            compare_set("flush");
        end
        end_test("flush");

        for (int i = 0; i < 30; i++) begin
            s = llc_set_t'($urandom_range(NUM_SETS - 1));
            w = llc_way_t'($urandom_range(`LLC_WAYS - 1));
            req = rand_write_req(s, w);
            req.wr_en = $urandom_range(1);
            req.wr_en_evict_way = 1'b1;
            req.evict_way = llc_way_t'($urandom_range(`LLC_WAYS - 1));
            drive_cycle(req, 1'b0);
            read_set(s);
            compare_set("evict");
            read_set(llc_set_t'($urandom_range(NUM_SETS - 1)));
            compare_set("evict");
        end
        end_test("evict");

        s = llc_set_t'($urandom_range(NUM_SETS - 1));
        w = llc_way_t'($urandom_range(`LLC_WAYS - 1));
        req = rand_write_req(s, w);
        req.wr_en_evict_way = 1'b1;
        req.evict_way = llc_way_t'($urandom_range(`LLC_WAYS - 1));
        drive_cycle(req, 1'b0);
        read_set(s);
        compare_set("hold");
        // outputs stay put without a strobe
        for (int i = 0; i < 3; i++) begin
            req = rand_write_req(s, w);
            req.wr_en_evict_way = 1'b1;
            req.evict_way = llc_way_t'($urandom_range(`LLC_WAYS - 1));
            drive_cycle(req, 1'b0);
            compare_set("hold");
        end
        drive_cycle(rand_write_req(s, w), 1'b1);
        wait_read();
        compare_set("read_first");
        read_set(s);
        compare_set("read_first");
        end_test("hold_read_first");

        finish_run();
    end

endmodule

// ==== verilog.f ====
+incdir+.
llc_mem_pkg.sv
llc_port_pkg.sv
llc_write_decode.sv
llc_way_array.sv
llc_set_view.sv
llc_localmem.sv
tb_llc_localmem.sv

// ==== Bender.yml ====
package:
  name: llc_localmem

sources:
  - include_dirs:
      - .
    files:
      - llc_mem_pkg.sv
      - llc_port_pkg.sv
      - llc_write_decode.sv
      - llc_way_array.sv
      - llc_set_view.sv
      - llc_localmem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_llc_localmem.sv
